/* src/icache_pkg.sv */
// Instruction cache shared parameters, array and bus structs, fault causes
`default_nettype none

package icache_pkg;

  localparam int unsigned PhysAddrLen  = 32;
  localparam int unsigned WaysWidth    = 2;
  localparam int unsigned NumWays      = 2 ** WaysWidth;
  localparam int unsigned SetsWidth    = 6;
  localparam int unsigned NumSets      = 2 ** SetsWidth;
  localparam int unsigned LineWords    = 8;
  localparam int unsigned WordIdxWidth = 3;
  // Line offset is 6 bits, the rest above the set index is tag
  localparam int unsigned TagWidth     = PhysAddrLen - SetsWidth - 6;

  typedef struct packed {
    logic                valid;
    logic [TagWidth-1:0] tag;
  } tag_t;

  typedef logic [SetsWidth-1:0] set_idx_t;
  typedef logic [WaysWidth-1:0] way_idx_t;
  typedef logic [NumWays-1:0]   way_mask_t;

  typedef struct packed {
    logic                    en;
    set_idx_t                set;
    logic [WordIdxWidth-1:0] word;
  } array_rd_t;

  typedef struct packed {
    way_mask_t               ways;
    set_idx_t                set;
    logic [WordIdxWidth-1:0] word;
    logic                    tag_en;
    logic                    data_en;
    tag_t                    tag;
    logic [63:0]             data;
  } array_wr_t;

  typedef enum logic [3:0] {
    ExcCauseNone             = 4'd0,
    ExcCauseInstrAccessFault = 4'd1
  } fault_cause_e;

  typedef struct packed {
    logic        valid;
    logic        flush;
    logic [63:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic         valid;
    logic         fault;
    logic [31:0]  instr;
    fault_cause_e cause;
    logic [63:0]  tval;
  } fetch_resp_t;

  // Wishbone classic, master to slave and back
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [7:0]  sel;
  } wb_m2s_t;

  typedef struct packed {
    logic        ack;
    logic        err;
    logic [63:0] dat;
  } wb_s2m_t;

endpackage

`default_nettype wire

/* src/icache_ram_2p.sv */
// Two-port synchronous RAM with one registered read port and one write port
`timescale 1ns/1ps
`default_nettype none

module icache_ram_2p #(
  parameter type         word_t = logic [63:0],
  parameter int unsigned Depth  = 64
) (
  input  logic                     clk_i,

  // Read port, data valid on the following cycle
  input  logic                     rd_en_i,
  input  logic [$clog2(Depth)-1:0] rd_addr_i,
  output word_t                    rd_data_o,

  // Write port
  input  logic                     wr_en_i,
  input  logic [$clog2(Depth)-1:0] wr_addr_i,
  input  word_t                    wr_data_i
);

  word_t mem_q [Depth];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
  end

  // Old contents are returned on a collision, the caller bypasses
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_addr_i];
    end
  end

endmodule

`default_nettype wire

/* src/icache_arrays.sv */
// Tag and data arrays for all ways with write source select and read bypass
`timescale 1ns/1ps
`default_nettype none

module icache_arrays import icache_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,

  input  array_rd_t                   rd_i,
  input  array_wr_t                   flush_wr_i,
  input  array_wr_t                   refill_wr_i,

  output tag_t      [NumWays-1:0]     tags_o,
  output logic      [NumWays-1:0][63:0] data_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Write source select
  ////////////////////////////////////////////////////////////////////////////

  logic      flush_wr_valid;
  logic      refill_wr_valid;
  array_wr_t wr;

  assign flush_wr_valid  = flush_wr_i.tag_en || flush_wr_i.data_en;
  assign refill_wr_valid = refill_wr_i.tag_en || refill_wr_i.data_en;

  // Flush wins, although the controller never runs both together
  assign wr = flush_wr_valid ? flush_wr_i : refill_wr_i;

  ////////////////////////////////////////////////////////////////////////////
  // Bypass of a write that collides with the read issued in the same cycle
  ////////////////////////////////////////////////////////////////////////////

  // Shared by all ways, per-way hit flags pick it up
  tag_t        tag_byp_q;
  logic [63:0] data_byp_q;

  always_ff @(posedge clk_i) begin
    if (rd_i.en) begin
      tag_byp_q  <= wr.tag;
      data_byp_q <= wr.data;
    end
  end

  for (genvar w = 0; w < NumWays; w++) begin : g_way
    logic        tag_byp_hit_q;
    logic        data_byp_hit_q;
    tag_t        tag_raw;
    logic [63:0] data_raw;

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        tag_byp_hit_q  <= 1'b0;
        data_byp_hit_q <= 1'b0;
      end else if (rd_i.en) begin
        tag_byp_hit_q  <= wr.tag_en && wr.ways[w] && (wr.set == rd_i.set);
        data_byp_hit_q <= wr.data_en && wr.ways[w] &&
                          ({wr.set, wr.word} == {rd_i.set, rd_i.word});
      end
    end

    icache_ram_2p #(
      .word_t (tag_t),
      .Depth  (NumSets)
    ) u_tag_ram (
      .clk_i     (clk_i),
      .rd_en_i   (rd_i.en),
      .rd_addr_i (rd_i.set),
      .rd_data_o (tag_raw),
      .wr_en_i   (wr.tag_en && wr.ways[w]),
      .wr_addr_i (wr.set),
      .wr_data_i (wr.tag)
    );

    icache_ram_2p #(
      .word_t (logic [63:0]),
      .Depth  (NumSets * LineWords)
    ) u_data_ram (
      .clk_i     (clk_i),
      .rd_en_i   (rd_i.en),
      .rd_addr_i ({rd_i.set, rd_i.word}),
      .rd_data_o (data_raw),
      .wr_en_i   (wr.data_en && wr.ways[w]),
      .wr_addr_i ({wr.set, wr.word}),
      .wr_data_i (wr.data)
    );

    assign tags_o[w] = tag_byp_hit_q ? tag_byp_q : tag_raw;
    assign data_o[w] = data_byp_hit_q ? data_byp_q : data_raw;
  end

  // Refill and flush are sequenced by the controller, never both at once
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(flush_wr_valid && refill_wr_valid));

endmodule

`default_nettype wire

/* src/icache_refill.sv */
// Line refill unit that reads eight words over Wishbone and writes them into one way
`timescale 1ns/1ps
`default_nettype none

module icache_refill import icache_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  logic                   start_i,
  input  logic [PhysAddrLen-7:0] line_addr_i,
  input  way_idx_t               way_i,

  output wb_m2s_t                wb_o,
  input  wb_s2m_t                wb_i,

  output array_wr_t              wr_o,
  output logic                   done_o,
  output logic                   err_o
);

  logic                    busy_q;
  logic [WordIdxWidth-1:0] word_q;
  logic [PhysAddrLen-7:0]  line_q;
  way_idx_t                way_q;
  logic                    last_beat;

  assign last_beat = &word_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      word_q <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      word_q <= '0;
    end else if (busy_q) begin
      if (wb_i.err || (wb_i.ack && last_beat)) begin
        busy_q <= 1'b0;
      end
      if (wb_i.ack) begin
        word_q <= word_q + 1'b1;
      end
    end
  end

  // Line and way held for the whole burst
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      line_q <= line_addr_i;
      way_q  <= way_i;
    end
  end

  // Bus master holds cyc across all beats of the line
  assign wb_o.cyc = busy_q;
  assign wb_o.stb = busy_q;
  assign wb_o.we  = 1'b0;
  assign wb_o.adr = {line_q, word_q, 3'b000};
  assign wb_o.sel = '1;

  // One array write per acked word
  assign wr_o.ways      = way_mask_t'(1) << way_q;
  assign wr_o.set       = line_q[SetsWidth-1:0];
  assign wr_o.word      = word_q;
  assign wr_o.data_en   = busy_q && wb_i.ack;
  assign wr_o.data      = wb_i.dat;
  // Old line dropped with the first word and new tag made valid with the last
  assign wr_o.tag_en    = busy_q && wb_i.ack && (word_q == '0 || last_beat);
  assign wr_o.tag.valid = last_beat;
  assign wr_o.tag.tag   = line_q[PhysAddrLen-7:SetsWidth];

  assign done_o = busy_q && (wb_i.err || (wb_i.ack && last_beat));
  assign err_o  = busy_q && wb_i.err;

  // A new line is only started while the bus is idle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |-> !busy_q);

  // A beat keeps its address until the slave answers
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_o.stb && !wb_i.ack && !wb_i.err |=> wb_o.stb && $stable(wb_o.adr));

endmodule

`default_nettype wire

/* src/icache_flush.sv */
// Invalidate-all sweep over every set and way, after reset and on request
`timescale 1ns/1ps
`default_nettype none

module icache_flush import icache_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,

  input  logic      start_i,
  output array_wr_t wr_o,
  output logic      done_o
);

  logic     active_q;
  set_idx_t idx_q;

  // Sweep starts straight out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b1;
      idx_q    <= '0;
      done_o   <= 1'b0;
    end else begin
      done_o <= active_q && (&idx_q);
      if (start_i) begin
        active_q <= 1'b1;
        idx_q    <= '0;
      end else if (active_q) begin
        idx_q <= idx_q + 1'b1;
        if (&idx_q) active_q <= 1'b0;
      end
    end
  end

  // All ways of one set per cycle, invalid tag
  assign wr_o.ways    = '1;
  assign wr_o.set     = idx_q;
  assign wr_o.word    = '0;
  assign wr_o.tag_en  = active_q;
  assign wr_o.data_en = 1'b0;
  assign wr_o.tag     = '0;
  assign wr_o.data    = '0;

endmodule

`default_nettype wire

/* src/icache_ctrl.sv */
// Fetch controller with hit detection, victim choice, refill and flush sequencing
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl import icache_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  fetch_req_t                 req_i,
  output logic                       req_ready_o,
  output fetch_resp_t                resp_o,

  output array_rd_t                  rd_o,
  input  tag_t [NumWays-1:0]         tags_i,
  input  logic [NumWays-1:0][63:0]   data_i,

  output logic                       refill_start_o,
  output logic [PhysAddrLen-7:0]     refill_line_o,
  output way_idx_t                   refill_way_o,
  input  logic                       refill_done_i,
  input  logic                       refill_err_i,

  output logic                       flush_start_o,
  input  logic                       flush_done_i
);

  typedef enum logic [2:0] {
    StateInit, StateIdle, StateLookup, StateFill, StateFlush
  } state_e;

  state_e       state_q, state_d;
  logic [63:0]  pc_q;
  logic [63:0]  rd_pc;
  logic         rd_en;
  logic         rd_from_req;
  way_idx_t     victim_q;
  way_mask_t    hit;
  way_idx_t     sel_way;
  logic [63:0]  sel_data;
  fetch_resp_t  resp_d;

  ////////////////////////////////////////////////////////////////////////////
  // Hit detection and way choice
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit     = '0;
    sel_way = victim_q;
    for (int w = 0; w < NumWays; w++) begin
      hit[w] = tags_i[w].valid && (tags_i[w].tag == pc_q[PhysAddrLen-1 -: TagWidth]);
    end
    // Lowest invalid way beats the round-robin victim
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!tags_i[w].valid) sel_way = way_idx_t'(w);
    end
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (hit[w]) sel_way = way_idx_t'(w);
    end
  end

  assign sel_data = data_i[sel_way];

  ////////////////////////////////////////////////////////////////////////////
  // Fetch FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    rd_en          = 1'b0;
    rd_from_req    = 1'b0;
    refill_start_o = 1'b0;
    flush_start_o  = 1'b0;
    resp_d         = '0;
    resp_d.cause   = ExcCauseNone;
    unique case (state_q)
      // Wait for the sweep that runs out of reset
      StateInit: if (flush_done_i) state_d = StateIdle;
      StateIdle: begin
        if (req_i.valid) begin
          if (|req_i.pc[63:PhysAddrLen]) begin
            resp_d.valid = 1'b1;
            resp_d.fault = 1'b1;
            resp_d.cause = ExcCauseInstrAccessFault;
            resp_d.tval  = req_i.pc;
          end else if (req_i.flush) begin
            flush_start_o = 1'b1;
            state_d       = StateFlush;
          end else begin
            rd_en       = 1'b1;
            rd_from_req = 1'b1;
            state_d     = StateLookup;
          end
        end
      end
      StateLookup: begin
        if (|hit) begin
          resp_d.valid = 1'b1;
          resp_d.instr = pc_q[2] ? sel_data[63:32] : sel_data[31:0];
          state_d      = StateIdle;
        end else begin
          refill_start_o = 1'b1;
          state_d        = StateFill;
        end
      end
      StateFill: begin
        if (refill_done_i && refill_err_i) begin
          resp_d.valid = 1'b1;
          resp_d.fault = 1'b1;
          resp_d.cause = ExcCauseInstrAccessFault;
          resp_d.tval  = pc_q;
          state_d      = StateIdle;
        end else if (refill_done_i) begin
          rd_en   = 1'b1;
          state_d = StateLookup;
        end
      end
      // Replay once the requested sweep ends
      StateFlush: begin
        if (flush_done_i) begin
          rd_en   = 1'b1;
          state_d = StateLookup;
        end
      end
      default: state_d = StateIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= StateInit;
      victim_q <= '0;
      resp_o   <= '0;
    end else begin
      state_q <= state_d;
      resp_o  <= resp_d;
      if (refill_start_o) victim_q <= victim_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == StateIdle && req_i.valid) pc_q <= req_i.pc;
  end

  assign req_ready_o = (state_q == StateIdle);

  assign rd_pc       = rd_from_req ? req_i.pc : pc_q;
  assign rd_o.en     = rd_en;
  assign rd_o.set    = rd_pc[6 +: SetsWidth];
  assign rd_o.word   = rd_pc[3 +: WordIdxWidth];

  assign refill_line_o = pc_q[PhysAddrLen-1:6];
  assign refill_way_o  = sel_way;

  // The replay after a good refill must find the new line
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == StateFill && refill_done_i && !refill_err_i |=> |hit);

endmodule

`default_nettype wire

/* src/icache_top.sv */
// Instruction cache top level, joins controller, arrays, refill and flush units
`timescale 1ns/1ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  fetch_req_t  req_i,
  output logic        req_ready_o,
  output fetch_resp_t resp_o,

  output wb_m2s_t     wb_o,
  input  wb_s2m_t     wb_i
);

  array_rd_t                rd;
  tag_t [NumWays-1:0]       tags;
  logic [NumWays-1:0][63:0] data;
  array_wr_t                flush_wr;
  array_wr_t                refill_wr;
  logic                     refill_start;
  logic [PhysAddrLen-7:0]   refill_line;
  way_idx_t                 refill_way;
  logic                     refill_done;
  logic                     refill_err;
  logic                     flush_start;
  logic                     flush_done;

  icache_ctrl u_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_ready_o    (req_ready_o),
    .resp_o         (resp_o),
    .rd_o           (rd),
    .tags_i         (tags),
    .data_i         (data),
    .refill_start_o (refill_start),
    .refill_line_o  (refill_line),
    .refill_way_o   (refill_way),
    .refill_done_i  (refill_done),
    .refill_err_i   (refill_err),
    .flush_start_o  (flush_start),
    .flush_done_i   (flush_done)
  );

  icache_arrays u_arrays (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_i        (rd),
    .flush_wr_i  (flush_wr),
    .refill_wr_i (refill_wr),
    .tags_o      (tags),
    .data_o      (data)
  );

  icache_refill u_refill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (refill_start),
    .line_addr_i (refill_line),
    .way_i       (refill_way),
    .wb_o        (wb_o),
    .wb_i        (wb_i),
    .wr_o        (refill_wr),
    .done_o      (refill_done),
    .err_o       (refill_err)
  );

  icache_flush u_flush (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (flush_start),
    .wr_o    (flush_wr),
    .done_o  (flush_done)
  );

endmodule

`default_nettype wire

/* bench/wb_mem_model.sv */
// Wishbone classic slave with random wait states and an address-derived data pattern
`timescale 1ns/1ps
`default_nettype none

module wb_mem_model import icache_pkg::*; #(
  parameter logic [31:0] ErrBase = 32'hF000_0000
) (
  input  logic    clk_i,
  input  logic    rst_ni,

  input  wb_m2s_t wb_i,
  output wb_s2m_t wb_o
);

  logic        pending_q;
  int unsigned wait_q;

  always @(posedge clk_i or negedge rst_ni) begin : p_slave
    int unsigned wait_now;
    if (!rst_ni) begin
      wb_o      <= '0;
      pending_q <= 1'b0;
      wait_q    <= 0;
    end else begin
      wb_o.ack <= 1'b0;
      wb_o.err <= 1'b0;
      // Skip the cycle right after an answer, the master moves on at this edge
      if (wb_i.cyc && wb_i.stb && !wb_o.ack && !wb_o.err) begin
        wait_now = pending_q ? wait_q : ($urandom % 4);
        if (wait_now == 0) begin
          pending_q <= 1'b0;
          if (wb_i.adr >= ErrBase) begin
            wb_o.err <= 1'b1;
          end else begin
            wb_o.ack <= 1'b1;
            wb_o.dat <= {wb_i.adr, ~wb_i.adr};
          end
        end else begin
          pending_q <= 1'b1;
          wait_q    <= wait_now - 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* bench/icache_tb.sv */
// Instruction cache testbench with a replacement model and a table of fetches
`timescale 1ns/1ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

  localparam logic [31:0] ErrBase = 32'hF000_0000;

  typedef struct packed {
    logic [63:0] pc;
    logic        flush;
    fetch_resp_t resp;
    logic [31:0] lines;
  } entry_t;

  logic        clk;
  logic        rst_n;
  fetch_req_t  req;
  logic        req_ready;
  fetch_resp_t resp;
  wb_m2s_t     wb_m2s;
  wb_s2m_t     wb_s2m;

  entry_t      stim_table[$];
  logic        table_ready = 1'b0;
  logic        timed_out = 1'b0;
  int unsigned resp_errors = 0;
  int unsigned line_errors = 0;
  int unsigned bus_errors = 0;
  int unsigned lines_fetched = 0;
  logic        cyc_prev = 1'b0;

  // Replacement model that starts with every way invalid after the reset sweep
  logic                model_valid [NumSets][NumWays];
  logic [TagWidth-1:0] model_tag   [NumSets][NumWays];
  way_idx_t            model_victim;

  icache_top uut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_i       (req),
    .req_ready_o (req_ready),
    .resp_o      (resp),
    .wb_o        (wb_m2s),
    .wb_i        (wb_s2m)
  );

  wb_mem_model #(
    .ErrBase (ErrBase)
  ) u_mem (
    .clk_i  (clk),
    .rst_ni (rst_n),
    .wb_i   (wb_m2s),
    .wb_o   (wb_s2m)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Each rising edge of cyc is one line fetched and every beat is a full read
  always @(posedge clk) begin
    if (wb_m2s.cyc && !cyc_prev) lines_fetched <= lines_fetched + 1;
    if (wb_m2s.cyc) check_bus(wb_m2s);
    cyc_prev <= wb_m2s.cyc;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table construction with expected values
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_entry(input logic [63:0] pc, input logic flush);
    entry_t      e;
    logic [31:0] adr;
    set_idx_t    set;
    way_idx_t    way;
    logic        hit;
    logic        found;
    e            = '0;
    e.pc         = pc;
    e.flush      = flush;
    e.resp.valid = 1'b1;
    adr          = {pc[31:3], 3'b000};
    set          = pc[6 +: SetsWidth];
    hit          = 1'b0;
    found        = 1'b0;
    if (|pc[63:PhysAddrLen]) begin
      e.resp.fault = 1'b1;
      e.resp.cause = ExcCauseInstrAccessFault;
      e.resp.tval  = pc;
    end else begin
      if (flush) begin
        for (int s = 0; s < NumSets; s++) begin
          for (int w = 0; w < NumWays; w++) model_valid[s][w] = 1'b0;
        end
      end
      for (int w = 0; w < NumWays; w++) begin
        if (model_valid[set][w] && model_tag[set][w] == pc[PhysAddrLen-1 -: TagWidth]) begin
          hit = 1'b1;
        end
      end
      if (!hit) begin
        e.lines = 32'd1;
        way     = model_victim;
        for (int w = 0; w < NumWays; w++) begin
          if (!found && !model_valid[set][w]) begin
            way   = way_idx_t'(w);
            found = 1'b1;
          end
        end
        model_victim = model_victim + 1'b1;
        // A bus error leaves the set untouched
        if (adr >= ErrBase) begin
          e.resp.fault = 1'b1;
          e.resp.cause = ExcCauseInstrAccessFault;
          e.resp.tval  = pc;
        end else begin
          model_valid[set][way] = 1'b1;
          model_tag[set][way]   = pc[PhysAddrLen-1 -: TagWidth];
        end
      end
      if (!e.resp.fault) e.resp.instr = pc[2] ? adr : ~adr;
    end
    stim_table.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] r;
    logic [31:0] pc32;
    for (int s = 0; s < NumSets; s++) begin
      for (int w = 0; w < NumWays; w++) model_valid[s][w] = 1'b0;
    end
    model_victim = '0;
    // One line with both halves of a word and other words
    add_entry(64'h8000_0040, 1'b0);
    add_entry(64'h8000_0044, 1'b0);
    add_entry(64'h8000_0040, 1'b0);
    add_entry(64'h8000_0058, 1'b0);
    add_entry(64'h8000_007c, 1'b0);
    // Five tags in set 5 and then the first two again
    for (int t = 0; t < 5; t++) add_entry(64'h8001_0140 + (64'(t) << 12), 1'b0);
    add_entry(64'h8001_0140, 1'b0);
    add_entry(64'h8001_1144, 1'b0);
    // Flush and then lines cached before it
    add_entry(64'h8000_0048, 1'b1);
    add_entry(64'h8000_0040, 1'b0);
    add_entry(64'h8001_0140, 1'b0);
    add_entry(64'h8001_4148, 1'b0);
    // The range fault for bits above the physical address wins over a flush
    add_entry(64'h0000_0001_8000_0040, 1'b0);
    add_entry(64'h8000_0000_0000_0000, 1'b1);
    // Error region twice and then a normal fetch
    add_entry(64'h0000_0000_f000_0104, 1'b0);
    add_entry(64'h0000_0000_f000_0104, 1'b0);
    add_entry(64'h8000_0044, 1'b0);
    // Random pcs over sets 0 to 3 with eight tags and some flushes
    for (int i = 0; i < 24; i++) begin
      r    = $urandom;
      pc32 = {4'h8, 13'h0, r[2:0], 4'h0, r[4:3], r[8:5], 2'b00};
      add_entry({32'h0, pc32}, r[15:13] == 3'b000);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks and the run
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_resp(input int idx, input fetch_resp_t got, input fetch_resp_t want);
    if (got !== want) begin
      resp_errors++;
      $display("MISMATCH resp_o entry %0d: got %h expected %h", idx, got, want);
    end
  endtask

  task automatic check_lines(input int idx, input int unsigned got, input int unsigned want);
    if (got != want) begin
      line_errors++;
      $display("MISMATCH lines_fetched entry %0d: got %h expected %h", idx, got, want);
    end
  endtask

  task automatic check_bus(input wb_m2s_t got);
    if (got.we !== 1'b0 || got.sel !== 8'hff) begin
      bus_errors++;
      $display("MISMATCH wb_o: got we %h sel %h expected we 0 sel ff", got.we, got.sel);
    end
  endtask

  // Starts and ends at 1 ns after a rising edge
  task automatic apply_entry(input int idx, input entry_t e);
    int unsigned lines_before;
    while (!req_ready) begin
      @(posedge clk);
      #1;
    end
    lines_before = lines_fetched;
    req.valid    = 1'b1;
    req.flush    = e.flush;
    req.pc       = e.pc;
    @(posedge clk);
    #1;
    req = '0;
    while (!resp.valid) begin
      @(posedge clk);
      #1;
    end
    check_resp(idx, resp, e.resp);
    check_lines(idx, lines_fetched - lines_before, e.lines);
  endtask

  task automatic finish_run();
    $display("Error counts: %0d response, %0d line count, %0d bus, %0d timeout",
             resp_errors, line_errors, bus_errors, timed_out);
    if (resp_errors == 0 && line_errors == 0 && bus_errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  initial begin
    void'($urandom(32'h851d_03c2));
    rst_n = 1'b0;
    req   = '0;
    build_table();
    table_ready = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < stim_table.size(); i++) apply_entry(i, stim_table[i]);
    finish_run();
  end

  initial begin : watchdog
    int unsigned limit;
    wait (table_ready);
    limit = stim_table.size() * 200;
    repeat (limit) @(posedge clk);
    $display("Timeout: the cache did not finish the table within %0d cycles", limit);
    timed_out = 1'b1;
    finish_run();
  end

endmodule

`default_nettype wire

/* build.f */
src/icache_pkg.sv
src/icache_ram_2p.sv
src/icache_arrays.sv
src/icache_refill.sv
src/icache_flush.sv
src/icache_ctrl.sv
src/icache_top.sv
bench/wb_mem_model.sv
bench/icache_tb.sv

/* run.sh */
#!/bin/sh
# Build the instruction cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module icache_tb -o icache_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/icache_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -Fqx '** PASS **'; then
  exit 0
fi
exit 1
